// File: rtl/busPkg.sv
package busPkg;

    // Source index map, a higher index wins arbitration
    //   10  DMA engine
    //    9  I-cache even half
    //    8  I-cache odd half
    //    7  D-cache even write
    //    6  D-cache odd write
    //    5  D-cache even read
    //    4  D-cache odd read
    //  3-0  memory banks 0 to 3
    localparam int NumSrc = 11;

    // Destination index map
    //    0  I-cache even half
    //    1  I-cache odd half
    //    2  D-cache even side
    //    3  D-cache odd side
    //  4-7  memory banks 0 to 3
    //    8  DMA engine
    localparam int NumDst = 9;

    localparam int SrcW = 4;
    localparam int DstW = 4;

    typedef logic [SrcW-1:0] SrcIdx;
    typedef logic [DstW-1:0] DstIdx;

    // One bus request, sender in the upper nibble
    typedef struct packed {
        SrcIdx sender;
        DstIdx dest;
    } busReqT;

endpackage

// File: rtl/busHoldTimer.sv
`timescale 1ns/1ps

module busHoldTimer #(
    parameter int MaxHold = 16
) (
    input  logic clk,
    input  logic rstN,
    input  logic timerRun,
    output logic expired
);

    localparam int CntW = $clog2(MaxHold);
    localparam logic [CntW-1:0] LastCycle = CntW'(MaxHold - 1);

    logic [CntW-1:0] count;

    // Count is zero in the first tenure cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= '0;
        end else if (!timerRun) begin
            count <= '0;
        end else if (count != LastCycle) begin
            count <= count + 1'b1;           // Saturates at the last cycle
        end
    end

    assign expired = timerRun && (count == LastCycle);

endmodule

// File: rtl/busGrantDecode.sv
`timescale 1ns/1ps

module busGrantDecode (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      pull,
    input  logic                      endTenure,
    input  busPkg::busReqT            head,
    output logic [busPkg::NumSrc-1:0] grant,
    output logic [busPkg::NumDst-1:0] recv
);
    import busPkg::*;

    logic [NumSrc-1:0] srcHot;
    logic [NumDst-1:0] dstHot;

    always_comb begin
        for (int i = 0; i < NumSrc; i++) begin
            srcHot[i] = (head.sender == SrcIdx'(i));
        end
        for (int j = 0; j < NumDst; j++) begin
            dstHot[j] = (head.dest == DstIdx'(j));
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            grant <= '0;
            recv  <= '0;
        end else if (pull) begin
            grant <= srcHot;
            recv  <= dstHot;
        end else if (endTenure) begin
            grant <= '0;                     // Release or forced expiry
            recv  <= '0;
        end
    end

endmodule

// File: rtl/busRequestQueue.sv
`timescale 1ns/1ps

module busRequestQueue (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic [busPkg::NumSrc-1:0]          req,
    input  busPkg::DstIdx [busPkg::NumSrc-1:0] dest,
    input  logic [busPkg::NumDst-1:0]          free,
    input  logic                               pull,
    output logic [busPkg::NumSrc-1:0]          ack,
    output busPkg::busReqT                     head,
    output logic                               headValid
);
    import busPkg::*;

    logic  [NumSrc-1:0] slotValid;
    DstIdx [NumSrc-1:0] slotDest;
    logic  [NumSrc-1:0] eligible;
    logic  [NumSrc-1:0] clearSlot;
    logic  [NumSrc-1:0] capture;

    // A slot competes only while its destination exists and is free
    always_comb begin
        for (int i = 0; i < NumSrc; i++) begin
            eligible[i] = slotValid[i]
                       && (slotDest[i] < DstIdx'(NumDst))
                       && free[slotDest[i]];
        end
    end

    // Fixed priority, later iterations override earlier ones
    always_comb begin
        head      = '0;
        headValid = 1'b0;
        for (int i = 0; i < NumSrc; i++) begin
            if (eligible[i]) begin
                head.sender = SrcIdx'(i);
                head.dest   = slotDest[i];
                headValid   = 1'b1;
            end
        end
    end

    // Pull empties the slot that head names
    always_comb begin
        for (int i = 0; i < NumSrc; i++) begin
            clearSlot[i] = pull && (head.sender == SrcIdx'(i));
        end
    end

    // A slot emptied at this edge can take a new request at the same edge
    always_comb begin
        for (int i = 0; i < NumSrc; i++) begin
            capture[i] = req[i] && (!slotValid[i] || clearSlot[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            slotValid <= '0;
            ack       <= '0;
        end else begin
            ack <= capture;                  // One-cycle ack per stored request
            for (int i = 0; i < NumSrc; i++) begin
                if (capture[i]) begin
                    slotValid[i] <= 1'b1;
                end else if (clearSlot[i]) begin
                    slotValid[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NumSrc; i++) begin
            if (capture[i]) begin
                slotDest[i] <= dest[i];
            end
        end
    end

endmodule

// File: rtl/busArbiterFsm.sv
`timescale 1ns/1ps

module busArbiterFsm (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      headValid,
    input  busPkg::SrcIdx             headSender,
    input  logic [busPkg::NumSrc-1:0] rel,
    input  logic [busPkg::NumSrc-1:0] grant,
    input  logic                      expired,
    output logic                      pull,
    output logic                      endTenure,
    output logic                      timerRun
);
    import busPkg::*;

    localparam logic Idle = 1'b0;
    localparam logic Hold = 1'b1;

    logic  state;
    logic  stateNext;
    SrcIdx heldSender;
    logic  holderRel;

    // Only the current holder may end its own tenure
    always_comb begin
        holderRel = 1'b0;
        if (heldSender < SrcIdx'(NumSrc)) begin
            holderRel = rel[heldSender] && grant[heldSender];
        end
    end

    always_comb begin
        pull      = (state == Idle) && headValid;
        endTenure = (state == Hold) && (holderRel || expired);
        timerRun  = (state == Hold);
    end

    always_comb begin
        stateNext = state;
        case (state)
            Idle: begin
                if (headValid) begin
                    stateNext = Hold;
                end
            end
            Hold: begin
                if (endTenure) begin
                    stateNext = Idle;        // At least one Idle cycle between tenures
                end
            end
            default: stateNext = Idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= Idle;
        end else begin
            state <= stateNext;
        end
    end

    always_ff @(posedge clk) begin
        if (pull) begin
            heldSender <= headSender;        // Latched with the grant
        end
    end

endmodule

// File: rtl/busTop.sv
`timescale 1ns/1ps

module busTop #(
    parameter int MaxHold = 16
) (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic [busPkg::NumSrc-1:0]          req,
    input  busPkg::DstIdx [busPkg::NumSrc-1:0] dest,
    input  logic [busPkg::NumDst-1:0]          free,
    input  logic [busPkg::NumSrc-1:0]          rel,
    output logic [busPkg::NumSrc-1:0]          ack,
    output logic [busPkg::NumSrc-1:0]          grant,
    output logic [busPkg::NumDst-1:0]          recv
);
    import busPkg::*;

    busReqT head;
    logic   headValid;
    logic   pull;
    logic   endTenure;
    logic   timerRun;
    logic   expired;

    busRequestQueue queue (
        .clk       (clk),
        .rstN      (rstN),
        .req       (req),
        .dest      (dest),
        .free      (free),
        .pull      (pull),
        .ack       (ack),
        .head      (head),
        .headValid (headValid)
    );

    busArbiterFsm fsm (
        .clk        (clk),
        .rstN       (rstN),
        .headValid  (headValid),
        .headSender (head.sender),
        .rel        (rel),
        .grant      (grant),
        .expired    (expired),
        .pull       (pull),
        .endTenure  (endTenure),
        .timerRun   (timerRun)
    );

    busHoldTimer #(
        .MaxHold (MaxHold)
    ) timer (
        .clk      (clk),
        .rstN     (rstN),
        .timerRun (timerRun),
        .expired  (expired)
    );

    busGrantDecode decode (
        .clk       (clk),
        .rstN      (rstN),
        .pull      (pull),
        .endTenure (endTenure),
        .head      (head),
        .grant     (grant),
        .recv      (recv)
    );

endmodule

// File: tests/busArb_sva.sv
`timescale 1ns/1ps

module busArbSva #(
    parameter int MaxHold = 16
) (
    input logic                      clk,
    input logic                      rstN,
    input logic [busPkg::NumSrc-1:0] grant,
    input logic [busPkg::NumDst-1:0] recv
);

    int holdCycles;                          // Cycles the current grant has been up

    always_ff @(posedge clk) begin
        if (!rstN) begin
            holdCycles <= 0;
        end else if (|grant) begin
            holdCycles <= holdCycles + 1;
        end else begin
            holdCycles <= 0;
        end
    end

    grantOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(grant))
        else $error("grant has more than one bit set");

    recvOneHot: assert property (@(posedge clk) disable iff (!rstN) $onehot0(recv))
        else $error("recv has more than one bit set");

    recvNeedsGrant: assert property (@(posedge clk) disable iff (!rstN) (|recv) |-> (|grant))
        else $error("recv is high with no grant");

    // Tenure of MaxHold cycles plus one cycle of margin
    grantBounded: assert property (@(posedge clk) disable iff (!rstN)
                                   (|grant) |-> (holdCycles <= MaxHold))
        else $error("grant held longer than the maximum tenure");

endmodule

bind busTop busArbSva #(
    .MaxHold (MaxHold)
) sva (
    .clk   (clk),
    .rstN  (rstN),
    .grant (grant),
    .recv  (recv)
);

// File: tests/busTb.sv
`timescale 1ns/1ps

module busTb;
    import busPkg::*;

    localparam int MaxHold     = 8;
    localparam int Period      = 100;
    localparam int DriveDelay  = 5;
    localparam int ResetCycles = 10;
    localparam int SlackCycles = 20;

    // One trace line, inputs first and expected outputs after them
    typedef struct packed {
        logic [3:0]         tag;
        logic [NumSrc-1:0]  req;
        DstIdx [NumSrc-1:0] dest;
        logic [NumDst-1:0]  free;
        logic [NumSrc-1:0]  rel;
        logic [NumSrc-1:0]  ack;
        logic [NumSrc-1:0]  grant;
        logic [NumDst-1:0]  recv;
    } traceLineT;

    logic               clk;
    logic               rstN;
    logic [NumSrc-1:0]  req;
    DstIdx [NumSrc-1:0] dest;
    logic [NumDst-1:0]  free;
    logic [NumSrc-1:0]  rel;
    logic [NumSrc-1:0]  ack;
    logic [NumSrc-1:0]  grant;
    logic [NumDst-1:0]  recv;

    traceLineT trace[$];
    bit        traceLoaded = 1'b0;
    int        lineNo;
    int        errors;
    int        testErrors;
    int        testsPassed;
    int        testsFailed;

    busTop #(
        .MaxHold (MaxHold)
    ) uut (
        .clk   (clk),
        .rstN  (rstN),
        .req   (req),
        .dest  (dest),
        .free  (free),
        .rel   (rel),
        .ack   (ack),
        .grant (grant),
        .recv  (recv)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(Period / 2) clk = ~clk;
        end
    end

    function automatic string testName(input logic [3:0] tag);
        case (tag)
            4'd1: return "idle after reset";
            4'd2: return "single request";
            4'd3: return "fixed priority";
            4'd4: return "busy destination";
            4'd5: return "repeated strobe";
            4'd6: return "hold expiry";
            default: return "unnamed";
        endcase
    endfunction

    task automatic loadTrace();
        int                     fd;
        int                     fields;
        string                  line;
        logic [3:0]             tagV;
        logic [11:0]            reqV;
        logic [DstW*NumSrc-1:0] destV;
        logic [11:0]            freeV;
        logic [11:0]            relV;
        logic [11:0]            ackV;
        logic [11:0]            grantV;
        logic [11:0]            recvV;
        traceLineT              entry;

        fd = $fopen("tests/busTrace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file tests/busTrace.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;                    // Blank line or column header
            end
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                             tagV, reqV, destV, freeV, relV, ackV, grantV, recvV);
            if (fields != 8) begin
                $display("A trace line could not be read: %s", line);
                errors++;
            end else begin
                entry.tag   = tagV;
                entry.req   = reqV[NumSrc-1:0];
                entry.dest  = destV;         // Leftmost digit is source 10
                entry.free  = freeV[NumDst-1:0];
                entry.rel   = relV[NumSrc-1:0];
                entry.ack   = ackV[NumSrc-1:0];
                entry.grant = grantV[NumSrc-1:0];
                entry.recv  = recvV[NumDst-1:0];
                trace.push_back(entry);
            end
        end
        $fclose(fd);
    endtask

    task automatic applyInputs(input traceLineT t);
        req  = t.req;
        dest = t.dest;
        free = t.free;
        rel  = t.rel;
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: trace entry %0d, %s = %0h, expected %0h",
                     lineNo, name, got, exp);
            errors++;
            testErrors++;
        end
    endtask

    task automatic closeTest(input logic [3:0] tag);
        if (testErrors == 0) begin
            $display("Test %0d (%s): passed", tag, testName(tag));
            testsPassed++;
        end else begin
            $display("Test %0d (%s): %0d mismatches", tag, testName(tag), testErrors);
            testsFailed++;
        end
        testErrors = 0;
    endtask

    task automatic endRun(input bit ok);
        if (ok) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    initial begin : stimulus
        int k;

        errors      = 0;
        testErrors  = 0;
        testsPassed = 0;
        testsFailed = 0;
        lineNo      = 0;
        rstN        = 1'b0;
        req         = '0;
        dest        = '0;
        free        = '0;
        rel         = '0;
        loadTrace();
        if (errors != 0 || trace.size() == 0) begin
            $display("No usable trace, the run stops before reset is released");
            endRun(1'b0);
        end else begin
            traceLoaded = 1'b1;
            repeat (ResetCycles) @(posedge clk);
            #DriveDelay rstN = 1'b1;
            for (k = 0; k < trace.size(); k++) begin
                @(posedge clk);
                #DriveDelay;                 // Outputs settled, inputs not yet changed
                if (k > 0 && trace[k].tag != trace[k-1].tag) begin
                    closeTest(trace[k-1].tag);
                end
                lineNo = k;
                checkValue("ack", 32'(ack), 32'(trace[k].ack));
                checkValue("grant", 32'(grant), 32'(trace[k].grant));
                checkValue("recv", 32'(recv), 32'(trace[k].recv));
                applyInputs(trace[k]);
            end
            closeTest(trace[trace.size()-1].tag);
            $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                     testsPassed + testsFailed, testsPassed, testsFailed, errors);
            endRun(errors == 0);
        end
    end

    initial begin : watchdog
        wait (traceLoaded);
        #((trace.size() + SlackCycles) * Period);
        $display("Timeout: the trace did not finish within %0d cycles",
                 trace.size() + SlackCycles);
        endRun(1'b0);
    end

endmodule

// File: tests/busTrace.txt
# tag req dest(src10..src0) free rel | expected ack grant recv, all hex
# One line per cycle, expected outputs are those seen after that cycle's rising edge
1 000 00000000000 1ff 000 000 000 000
1 000 00000000000 1ff 000 000 000 000
1 000 00000000000 1ff 000 000 000 000
2 020 00000600000 1ff 000 000 000 000
2 000 00000600000 1ff 000 020 000 000
2 000 00000600000 1ff 000 000 020 040
2 000 00000600000 1ff 000 000 020 040
2 000 00000600000 1ff 020 000 020 040
2 000 00000600000 1ff 000 000 000 000
2 000 00000600000 1ff 000 000 000 000
3 504 70100000300 1ff 000 000 000 000
3 000 70100000300 1ff 000 504 000 000
3 000 70100000300 1ff 400 000 400 080
3 000 70100000300 1ff 000 000 000 000
3 000 70100000300 1ff 100 000 100 002
3 000 70100000300 1ff 000 000 000 000
3 000 70100000300 1ff 004 000 004 008
3 000 70100000300 1ff 000 000 000 000
3 000 70100000300 1ff 000 000 000 000
4 208 08000000000 0ff 000 000 000 000
4 000 08000000000 0ff 000 208 000 000
4 000 08000000000 0ff 000 000 008 001
4 000 08000000000 0ff 008 000 008 001
4 000 08000000000 0ff 000 000 000 000
4 000 08000000000 1ff 000 000 000 000
4 000 08000000000 1ff 000 000 200 100
4 000 08000000000 1ff 200 000 200 100
4 000 08000000000 1ff 000 000 000 000
4 000 08000000000 1ff 000 000 000 000
5 040 00005000000 1df 000 000 000 000
5 040 00005000000 1df 000 040 000 000
5 000 00005000000 1df 000 000 000 000
5 000 00005000000 1ff 000 000 000 000
5 000 00005000000 1ff 000 000 040 020
5 000 00005000000 1ff 040 000 040 020
5 000 00005000000 1ff 000 000 000 000
5 000 00005000000 1ff 000 000 000 000
6 010 00000020004 1ff 000 000 000 000
6 000 00000020004 1ff 000 010 000 000
6 001 00000020004 1ff 000 000 010 004
6 000 00000020004 1ff 001 001 010 004
6 000 00000020004 1ff 000 000 010 004
6 000 00000020004 1ff 000 000 010 004
6 000 00000020004 1ff 000 000 010 004
6 000 00000020004 1ff 000 000 010 004
6 000 00000020004 1ff 000 000 010 004
6 000 00000020004 1ff 000 000 010 004
6 000 00000020004 1ff 000 000 000 000
6 000 00000020004 1ff 001 000 001 010
6 000 00000020004 1ff 000 000 000 000
6 000 00000020004 1ff 000 000 000 000

// File: tb.f
rtl/busPkg.sv
rtl/busHoldTimer.sv
rtl/busGrantDecode.sv
rtl/busRequestQueue.sv
rtl/busArbiterFsm.sv
rtl/busTop.sv
tests/busArb_sva.sv
tests/busTb.sv

// File: Makefile
# Verilator build and run of the bus arbiter testbench

VERILATOR   ?= verilator
TOP         ?= busTb
FILELIST    ?= tb.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS  ?= --lint-only --timing -Wall
PASS_TEXT   ?= PASS: all tests

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
